/* common/mem_access_pkg.sv */
package mem_access_pkg;

  localparam int DATA_WIDTH = 32;

  // Width of one core access
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } access_size_t;

  // LSU sequencing over the AXI-Lite channels
  typedef enum logic [2:0] {
    IDLE         = 3'd0,
    HANDLE_RADDR = 3'd1,
    HANDLE_RDATA = 3'd2,
    HANDLE_WADDR = 3'd3,
    HANDLE_WDATA = 3'd4,
    HANDLE_BRESP = 3'd5,
    WRITE_BACK   = 3'd6
  } lsu_state_t;

endpackage

/* common/axi_lite_pkg.sv */
package axi_lite_pkg;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_t;

  // Slave channel sequencing, one access at a time
  typedef enum logic [2:0] {
    S_IDLE       = 3'd0,
    S_READ_WAIT  = 3'd1,
    S_READ_RESP  = 3'd2,
    S_WRITE_DATA = 3'd3,
    S_WRITE_WAIT = 3'd4,
    S_WRITE_RESP = 3'd5
  } slave_state_t;

endpackage

/* lsu/lsu_lane_align.sv */
`timescale 1ns/1ps

module lsu_lane_align (
  input  logic [1:0]                              addr_low,
  input  mem_access_pkg::access_size_t            size,
  input  logic                                    sext,
  input  logic [mem_access_pkg::DATA_WIDTH-1:0]   wsrc,
  input  logic [mem_access_pkg::DATA_WIDTH-1:0]   rdata,
  output logic [mem_access_pkg::DATA_WIDTH-1:0]   wdata,
  output logic [mem_access_pkg::DATA_WIDTH/8-1:0] wstrb,
  output logic [mem_access_pkg::DATA_WIDTH-1:0]   load_data
);
  import mem_access_pkg::*;

  logic [4:0]            shamt;
  logic [DATA_WIDTH-1:0] rshift;

  assign shamt = {addr_low, 3'b000}; // Byte offset in bits

  // Store side
  always_comb begin
    unique case (size)
      SIZE_BYTE: begin
        wdata = wsrc << shamt;
        wstrb = 4'b0001 << addr_low;
      end
      SIZE_HALF: begin
        wdata = wsrc << shamt;
        wstrb = 4'b0011 << addr_low;
      end
      default: begin
        wdata = wsrc; // Word goes out unshifted
        wstrb = 4'b1111;
      end
    endcase
  end

  // Load side
  assign rshift = (size == SIZE_WORD) ? rdata : (rdata >> shamt);

  always_comb begin
    unique case (size)
      SIZE_BYTE: load_data = sext ? {{24{rshift[7]}}, rshift[7:0]} : {24'b0, rshift[7:0]};
      SIZE_HALF: load_data = sext ? {{16{rshift[15]}}, rshift[15:0]} : {16'b0, rshift[15:0]};
      default:   load_data = rshift;
    endcase
  end

endmodule

/* lsu/lsu.sv */
`timescale 1ns/1ps

module lsu (
  input  logic                                    clock,
  input  logic                                    reset,

  // Core side
  input  logic                                    ren,
  input  logic                                    wen,
  input  mem_access_pkg::access_size_t            size,
  input  logic                                    sext,
  input  logic [31:0]                             addr,
  input  logic [mem_access_pkg::DATA_WIDTH-1:0]   wsrc,
  output logic [mem_access_pkg::DATA_WIDTH-1:0]   mem_rdata,
  output logic                                    read_done,
  output logic                                    write_done,
  output logic                                    access_error,

  // AR
  output logic [31:0]                             araddr,
  output logic                                    arvalid,
  input  logic                                    arready,
  // R
  input  logic [mem_access_pkg::DATA_WIDTH-1:0]   rdata,
  input  axi_lite_pkg::axi_resp_t                 rresp,
  input  logic                                    rvalid,
  output logic                                    rready,
  // AW
  output logic [31:0]                             awaddr,
  output logic                                    awvalid,
  input  logic                                    awready,
  // W
  output logic [mem_access_pkg::DATA_WIDTH-1:0]   wdata,
  output logic [mem_access_pkg::DATA_WIDTH/8-1:0] wstrb,
  output logic                                    wvalid,
  input  logic                                    wready,
  // B
  input  axi_lite_pkg::axi_resp_t                 bresp,
  input  logic                                    bvalid,
  output logic                                    bready
);
  import mem_access_pkg::*;
  import axi_lite_pkg::*;

  lsu_state_t            state;
  logic [DATA_WIDTH-1:0] load_data;

  // Operands are held by the core, so the address feeds both channels directly
  assign araddr = addr;
  assign awaddr = addr;

  lsu_lane_align i_lane_align (
    .addr_low  (addr[1:0]),
    .size      (size),
    .sext      (sext),
    .wsrc      (wsrc),
    .rdata     (rdata),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .load_data (load_data)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= IDLE;
      arvalid      <= 1'b0;
      rready       <= 1'b0;
      awvalid      <= 1'b0;
      wvalid       <= 1'b0;
      bready       <= 1'b0;
      read_done    <= 1'b0;
      write_done   <= 1'b0;
      access_error <= 1'b0;
    end else begin
      unique case (state)
        IDLE: begin
          if (wen) begin // Write wins over a read
            awvalid <= 1'b1;
            state   <= HANDLE_WADDR;
          end else if (ren) begin
            arvalid <= 1'b1;
            state   <= HANDLE_RADDR;
          end
        end
        HANDLE_RADDR: begin
          if (arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            state   <= HANDLE_RDATA;
          end
        end
        HANDLE_RDATA: begin
          if (rvalid) begin
            rready       <= 1'b0;
            read_done    <= 1'b1;
            access_error <= (rresp != RESP_OKAY);
            state        <= WRITE_BACK;
          end
        end
        HANDLE_WADDR: begin
          if (awready) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b1;
            state   <= HANDLE_WDATA;
          end
        end
        HANDLE_WDATA: begin
          if (wready) begin
            wvalid <= 1'b0;
            bready <= 1'b1;
            state  <= HANDLE_BRESP;
          end
        end
        HANDLE_BRESP: begin
          if (bvalid) begin
            bready       <= 1'b0;
            write_done   <= 1'b1;
            access_error <= (bresp != RESP_OKAY);
            state        <= WRITE_BACK;
          end
        end
        WRITE_BACK: begin // Done pulse is visible here
          read_done    <= 1'b0;
          write_done   <= 1'b0;
          access_error <= 1'b0;
          state        <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Load result stays until the next load completes
  always_ff @(posedge clock) begin
    if (state == HANDLE_RDATA && rvalid && rready) mem_rdata <= load_data;
  end

  // Valid and address held through back-pressure, which relies on the core holding addr
  ar_hold: assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("arvalid or araddr dropped before arready");

  aw_hold: assert property (@(posedge clock) disable iff (reset)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else $error("awvalid or awaddr dropped before awready");

  done_pulse: assert property (@(posedge clock) disable iff (reset)
    (read_done || write_done) |=> !read_done && !write_done)
    else $error("done pulse longer than one cycle");

  no_dual_req: assert property (@(posedge clock) disable iff (reset)
    !(ren && wen))
    else $error("ren and wen raised together");

endmodule

/* src/axi_lite_sram.sv */
`timescale 1ns/1ps

module axi_lite_sram #(
  parameter int MEM_WORDS   = 1024,
  parameter int WAIT_CYCLES = 2
) (
  input  logic                                    clock,
  input  logic                                    reset,

  input  logic [31:0]                             araddr,
  input  logic                                    arvalid,
  output logic                                    arready,

  output logic [mem_access_pkg::DATA_WIDTH-1:0]   rdata,
  output axi_lite_pkg::axi_resp_t                 rresp,
  output logic                                    rvalid,
  input  logic                                    rready,

  input  logic [31:0]                             awaddr,
  input  logic                                    awvalid,
  output logic                                    awready,

  input  logic [mem_access_pkg::DATA_WIDTH-1:0]   wdata,
  input  logic [mem_access_pkg::DATA_WIDTH/8-1:0] wstrb,
  input  logic                                    wvalid,
  output logic                                    wready,

  output axi_lite_pkg::axi_resp_t                 bresp,
  output logic                                    bvalid,
  input  logic                                    bready
);
  import mem_access_pkg::*;
  import axi_lite_pkg::*;

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

  logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

  slave_state_t     state;
  logic [CNT_W-1:0] wait_cnt;
  logic             wait_done;
  logic             rd_in_range;
  logic             aw_in_range;
  logic [IDX_W-1:0] wr_index;
  logic             wr_error;

  assign wait_done   = (wait_cnt == CNT_W'(WAIT_CYCLES));
  assign arready     = (state == S_READ_WAIT) && wait_done;
  assign awready     = (state == S_WRITE_WAIT) && wait_done;
  assign wready      = (state == S_WRITE_DATA) && wait_done;
  assign rd_in_range = (araddr[31:2] < 30'(MEM_WORDS));
  assign aw_in_range = (awaddr[31:2] < 30'(MEM_WORDS));

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= S_IDLE;
      wait_cnt <= '0;
      rvalid   <= 1'b0;
      bvalid   <= 1'b0;
    end else begin
      unique case (state)
        S_IDLE: begin
          wait_cnt <= '0;
          if (awvalid) state <= S_WRITE_WAIT;
          else if (arvalid) state <= S_READ_WAIT;
        end
        S_READ_WAIT: begin
          if (arvalid && arready) begin
            rvalid <= 1'b1;
            state  <= S_READ_RESP;
          end else if (!wait_done) begin
            wait_cnt <= wait_cnt + CNT_W'(1);
          end
        end
        S_READ_RESP: begin
          if (rready) begin
            rvalid <= 1'b0;
            state  <= S_IDLE;
          end
        end
        S_WRITE_WAIT: begin
          if (awvalid && awready) begin
            wait_cnt <= '0; // Second wait before wready
            state    <= S_WRITE_DATA;
          end else if (!wait_done) begin
            wait_cnt <= wait_cnt + CNT_W'(1);
          end
        end
        S_WRITE_DATA: begin
          if (wvalid && wready) begin
            bvalid <= 1'b1;
            state  <= S_WRITE_RESP;
          end else if (!wait_done) begin
            wait_cnt <= wait_cnt + CNT_W'(1);
          end
        end
        S_WRITE_RESP: begin
          if (bready) begin
            bvalid <= 1'b0;
            state  <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (arvalid && arready) begin
      rdata <= rd_in_range ? mem[araddr[IDX_W+1:2]] : '0; // Out of range reads zero
      rresp <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
    end
    if (awvalid && awready) begin
      wr_index <= awaddr[IDX_W+1:2];
      wr_error <= !aw_in_range;
    end
    if (wvalid && wready) bresp <= wr_error ? RESP_SLVERR : RESP_OKAY;
  end

  // Strobed lane write
  always_ff @(posedge clock) begin
    if (wvalid && wready && !wr_error) begin
      for (int lane = 0; lane < DATA_WIDTH / 8; lane++) begin
        if (wstrb[lane]) mem[wr_index][8*lane +: 8] <= wdata[8*lane +: 8];
      end
    end
  end

  r_hold: assert property (@(posedge clock) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else $error("R response changed before rready");

  b_hold: assert property (@(posedge clock) disable iff (reset)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("B response changed before bready");

endmodule

/* src/lsu_subsystem.sv */
`timescale 1ns/1ps

module lsu_subsystem #(
  parameter int MEM_WORDS   = 1024,
  parameter int WAIT_CYCLES = 2
) (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  ren,
  input  logic                                  wen,
  input  mem_access_pkg::access_size_t          size,
  input  logic                                  sext,
  input  logic [31:0]                           addr,
  input  logic [mem_access_pkg::DATA_WIDTH-1:0] wsrc,
  output logic [mem_access_pkg::DATA_WIDTH-1:0] mem_rdata,
  output logic                                  read_done,
  output logic                                  write_done,
  output logic                                  access_error
);
  import mem_access_pkg::*;
  import axi_lite_pkg::*;

  // AXI-Lite channels between LSU and memory
  logic [31:0]             araddr;
  logic                    arvalid;
  logic                    arready;
  logic [DATA_WIDTH-1:0]   rdata;
  axi_resp_t               rresp;
  logic                    rvalid;
  logic                    rready;
  logic [31:0]             awaddr;
  logic                    awvalid;
  logic                    awready;
  logic [DATA_WIDTH-1:0]   wdata;
  logic [DATA_WIDTH/8-1:0] wstrb;
  logic                    wvalid;
  logic                    wready;
  axi_resp_t               bresp;
  logic                    bvalid;
  logic                    bready;

  lsu i_lsu (
    .clock        (clock),
    .reset        (reset),
    .ren          (ren),
    .wen          (wen),
    .size         (size),
    .sext         (sext),
    .addr         (addr),
    .wsrc         (wsrc),
    .mem_rdata    (mem_rdata),
    .read_done    (read_done),
    .write_done   (write_done),
    .access_error (access_error),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .arready      (arready),
    .rdata        (rdata),
    .rresp        (rresp),
    .rvalid       (rvalid),
    .rready       (rready),
    .awaddr       (awaddr),
    .awvalid      (awvalid),
    .awready      (awready),
    .wdata        (wdata),
    .wstrb        (wstrb),
    .wvalid       (wvalid),
    .wready       (wready),
    .bresp        (bresp),
    .bvalid       (bvalid),
    .bready       (bready)
  );

  axi_lite_sram #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) i_sram (
    .clock   (clock),
    .reset   (reset),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready)
  );

endmodule

/* verification/lsu_checker.sv */
`timescale 1ns/1ps

module lsu_checker #(
  parameter int MEM_WORDS = 1024
) (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  ren,
  input  logic                                  wen,
  input  mem_access_pkg::access_size_t          size,
  input  logic                                  sext,
  input  logic [31:0]                           addr,
  input  logic [mem_access_pkg::DATA_WIDTH-1:0] wsrc,
  input  logic [mem_access_pkg::DATA_WIDTH-1:0] mem_rdata,
  input  logic                                  read_done,
  input  logic                                  write_done,
  input  logic                                  access_error,
  input  int                                    test_id,
  output int                                    error_count,
  output int                                    check_count
);
  import mem_access_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [31:0]      ref_mem [MEM_WORDS];
  logic             req_pending;
  logic             req_write;
  access_size_t     req_size;
  logic             req_sext;
  logic [31:0]      req_addr;
  logic [31:0]      req_wsrc;
  logic [IDX_W-1:0] req_index;
  logic             req_in_range;

  assign req_index    = req_addr[IDX_W+1:2];
  assign req_in_range = (req_addr[31:2] < 30'(MEM_WORDS));

  function automatic string test_label(input int id);
    case (id)
      1:       return "word_store_load";
      2:       return "sub_word_store";
      3:       return "sub_word_load";
      4:       return "out_of_range";
      5:       return "random_run";
      default: return "reset";
    endcase
  endfunction

  // Expected load value picks the lanes and then extends
  function automatic logic [31:0] ref_load(input logic [31:0] word, input logic [1:0] offset,
                                           input access_size_t sz, input logic sx);
    logic [4:0]  bit_pos;
    logic [7:0]  b;
    logic [15:0] h;
    bit_pos = {offset, 3'b000};
    b = word[bit_pos +: 8];
    h = offset[1] ? word[31:16] : word[15:0];
    case (sz)
      SIZE_BYTE: return sx ? {{24{b[7]}}, b} : {24'h0, b};
      SIZE_HALF: return sx ? {{16{h[15]}}, h} : {16'h0, h};
      default:   return word;
    endcase
  endfunction

  // Only the addressed lanes take the low bytes of the source
  function automatic logic [31:0] ref_store(input logic [31:0] old, input logic [1:0] offset,
                                            input access_size_t sz, input logic [31:0] data);
    logic [4:0]  bit_pos;
    logic [31:0] word;
    bit_pos = {offset, 3'b000};
    word = old;
    case (sz)
      SIZE_BYTE: word[bit_pos +: 8] = data[7:0];
      SIZE_HALF: begin
        if (offset[1]) word[31:16] = data[15:0];
        else word[15:0] = data[15:0];
      end
      default: word = data;
    endcase
    return word;
  endfunction

  task automatic check_response();
    logic [31:0] expected;
    check_count++;
    if (!req_pending) begin
      $display("%s: done pulse at %0t with no open request", test_label(test_id), $time);
      error_count++;
    end else if (req_write != write_done) begin
      $display("%s: done pulse of the wrong kind for the access to %08h",
               test_label(test_id), req_addr);
      error_count++;
    end else begin
      if (access_error !== !req_in_range) begin
        $display("FAILED %s expected %0b actual %0b (access_error, addr %08h)",
                 test_label(test_id), !req_in_range, access_error, req_addr);
        error_count++;
      end
      if (req_write) begin
        if (req_in_range) begin
          ref_mem[req_index] = ref_store(ref_mem[req_index], req_addr[1:0], req_size, req_wsrc);
        end
      end else begin
        expected = req_in_range ?
                   ref_load(ref_mem[req_index], req_addr[1:0], req_size, req_sext) : 32'h0;
        if (mem_rdata !== expected) begin
          $display("FAILED %s expected %08h actual %08h (load at %08h)",
                   test_label(test_id), expected, mem_rdata, req_addr);
          error_count++;
        end
      end
    end
    req_pending = 1'b0;
  endtask

  always @(posedge clock) begin
    if (reset) begin
      req_pending = 1'b0;
      error_count = 0;
      check_count = 0;
    end else begin
      if (read_done || write_done) check_response();
      if (ren || wen) begin
        req_pending = 1'b1;
        req_write   = wen; // Write wins over a read
        req_size    = size;
        req_sext    = sext;
        req_addr    = addr;
        req_wsrc    = wsrc;
      end
    end
  end

endmodule

/* verification/tb_lsu_subsystem.sv */
`timescale 1ns/1ps

module tb_lsu_subsystem;
  import mem_access_pkg::*;

  localparam int MEM_WORDS    = 1024;
  localparam int WAIT_CYCLES  = 2;
  localparam int FILL_WORDS   = 16;
  localparam int RANDOM_OPS   = 200;
  // Fill and read back, sub-word stores, sub-word loads, range errors, random run
  localparam int NUM_ACCESSES = 2 * FILL_WORDS + 12 + 13 + 4 + RANDOM_OPS;
  localparam int CYCLE_LIMIT  = NUM_ACCESSES * (4 * WAIT_CYCLES + 10) + 100;

  logic                  clock = 1'b0;
  logic                  reset;
  logic                  ren;
  logic                  wen;
  access_size_t          size;
  logic                  sext;
  logic [31:0]           addr;
  logic [DATA_WIDTH-1:0] wsrc;
  logic [DATA_WIDTH-1:0] mem_rdata;
  logic                  read_done;
  logic                  write_done;
  logic                  access_error;

  int          test_id;
  int          error_count;
  int          check_count;
  int unsigned cycle_count = 0;
  logic [31:0] seed = 32'he6391349;

  always #4 clock = ~clock;

  lsu_subsystem #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) i_lsu_subsystem (
    .clock        (clock),
    .reset        (reset),
    .ren          (ren),
    .wen          (wen),
    .size         (size),
    .sext         (sext),
    .addr         (addr),
    .wsrc         (wsrc),
    .mem_rdata    (mem_rdata),
    .read_done    (read_done),
    .write_done   (write_done),
    .access_error (access_error)
  );

  lsu_checker #(
    .MEM_WORDS (MEM_WORDS)
  ) i_checker (
    .clock        (clock),
    .reset        (reset),
    .ren          (ren),
    .wen          (wen),
    .size         (size),
    .sext         (sext),
    .addr         (addr),
    .wsrc         (wsrc),
    .mem_rdata    (mem_rdata),
    .read_done    (read_done),
    .write_done   (write_done),
    .access_error (access_error),
    .test_id      (test_id),
    .error_count  (error_count),
    .check_count  (check_count)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // One request pulse with the operands held until the done pulse
  task automatic do_access(input logic write, input access_size_t sz, input logic sx,
                           input logic [31:0] a, input logic [31:0] data);
    size = sz;
    sext = sx;
    addr = a;
    wsrc = data;
    ren  = !write;
    wen  = write;
    @(negedge clock);
    ren = 1'b0;
    wen = 1'b0;
    while (!(read_done || write_done)) @(negedge clock);
    @(negedge clock); // LSU back in IDLE
  endtask

  task automatic store(input access_size_t sz, input logic [31:0] a, input logic [31:0] data);
    do_access(1'b1, sz, 1'b0, a, data);
  endtask

  task automatic load(input access_size_t sz, input logic sx, input logic [31:0] a);
    do_access(1'b0, sz, sx, a, 32'h0);
  endtask

  initial begin
    logic [31:0]  r;
    logic [1:0]   offset;
    access_size_t sz;
    reset   = 1'b1;
    ren     = 1'b0;
    wen     = 1'b0;
    size    = SIZE_WORD;
    sext    = 1'b0;
    addr    = 32'h0;
    wsrc    = 32'h0;
    test_id = 0;
    repeat (4) @(negedge clock);
    reset = 1'b0;

    test_id = 1;
    for (int i = 0; i < FILL_WORDS; i++) begin
      seed = lcg_next(seed);
      store(SIZE_WORD, 32'(4 * i), seed);
    end
    for (int i = 0; i < FILL_WORDS; i++) load(SIZE_WORD, 1'b0, 32'(4 * i));

    // Byte lanes of word 5, half lanes of word 6
    test_id = 2;
    for (int i = 0; i < 4; i++) begin
      seed = lcg_next(seed);
      store(SIZE_BYTE, 32'(20 + i), seed);
      load(SIZE_WORD, 1'b0, 32'd20);
    end
    for (int i = 0; i < 2; i++) begin
      seed = lcg_next(seed);
      store(SIZE_HALF, 32'(24 + 2 * i), seed);
      load(SIZE_WORD, 1'b0, 32'd24);
    end

    test_id = 3;
    store(SIZE_WORD, 32'd28, 32'h7f8a_8001); // Positive and negative bytes and halves
    for (int i = 0; i < 4; i++) begin
      for (int s = 0; s < 2; s++) load(SIZE_BYTE, 1'(s), 32'(28 + i));
    end
    for (int i = 0; i < 2; i++) begin
      for (int s = 0; s < 2; s++) load(SIZE_HALF, 1'(s), 32'(28 + 2 * i));
    end

    test_id = 4;
    load(SIZE_WORD, 1'b0, 32'(4 * MEM_WORDS));
    store(SIZE_WORD, 32'(4 * MEM_WORDS + 8), 32'hdead_beef); // Same low index bits as word 2
    load(SIZE_WORD, 1'b0, 32'd8);
    load(SIZE_BYTE, 1'b1, 32'hffff_fffd);

    // Upper LCG bits only since the low ones repeat too quickly
    test_id = 5;
    for (int n = 0; n < RANDOM_OPS; n++) begin
      seed = lcg_next(seed);
      r    = seed;
      seed = lcg_next(seed);
      case (r[25:24])
        2'd0: begin
          sz     = SIZE_BYTE;
          offset = r[27:26];
        end
        2'd1: begin
          sz     = SIZE_HALF;
          offset = {r[27], 1'b0};
        end
        default: begin
          sz     = SIZE_WORD;
          offset = 2'b00;
        end
      endcase
      do_access(r[29], sz, r[28], {26'h0, r[23:20], offset}, seed);
    end

    @(negedge clock);
    if (check_count != NUM_ACCESSES) begin
      $display("Expected %0d completed accesses, the checker saw %0d", NUM_ACCESSES, check_count);
    end
    $display("Accesses checked: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0 && check_count == NUM_ACCESSES) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: run still going after %0d cycles", cycle_count);
      $display("Something failed");
      $finish;
    end
  end

endmodule

/* project.f */
common/mem_access_pkg.sv
common/axi_lite_pkg.sv
lsu/lsu_lane_align.sv
lsu/lsu.sv
src/axi_lite_sram.sv
src/lsu_subsystem.sv
verification/lsu_checker.sv
verification/tb_lsu_subsystem.sv

/* run.sh */
#!/bin/sh
# Build and run the LSU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_lsu_subsystem -f project.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "Something failed" sim.log && exit 1 || exit 0
